// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= match_cluster_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= TESTS PASSED

.PHONY: sim clean

# the log decides the result, not the exit status of the simulator
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== src/credit_fifo.sv ====
module credit_fifo #(
    parameter type T = logic,
    parameter int DEPTH = 2
) (
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_push,
    input  T     i_data,
    input  logic i_pop,
    output T     o_data,
    output logic o_empty
);

    T mem [DEPTH];

    // one extra bit on each pointer tells a full buffer from an empty one
    logic [$clog2(DEPTH):0] wr_ptr;
    logic [$clog2(DEPTH):0] rd_ptr;
    logic                   do_pop;

    assign o_empty = (wr_ptr == rd_ptr);
    assign do_pop = i_pop && !o_empty;
    assign o_data = mem[rd_ptr[$clog2(DEPTH)-1:0]];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // the sender's credits keep a push from landing on a live entry
    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr[$clog2(DEPTH)-1:0]] <= i_data;
        end
    end

endmodule

// ==== src/lz_match_pkg.sv ====
package lz_match_pkg;

    localparam int HIST_ADDR_W = 8;
    localparam int HIST_SIZE = 1 << HIST_ADDR_W;
    localparam int NUM_LANES = 2;
    localparam int MAX_MATCH_LEN = 16;
    localparam int LEN_W = 5;

    // each buffer depth is also the starting credit of its sender
    localparam int REQ_GROUP_DEPTH = 4;
    localparam int LANE_REQ_DEPTH = 2;
    localparam int LANE_RESP_DEPTH = 2;
    localparam int OUT_CREDITS = 4;

    // issued but not yet emitted groups are bounded by what each lane can buffer
    // in its request FIFO plus the engine and response FIFO, which share the response credits
    localparam int ISSUE_DEPTH = NUM_LANES * (LANE_REQ_DEPTH + LANE_RESP_DEPTH);

    // counter widths hold 0 up to the full depth
    localparam int REQ_CRED_W = $clog2(LANE_REQ_DEPTH + 1);
    localparam int RESP_CRED_W = $clog2(LANE_RESP_DEPTH + 1);
    localparam int OUT_CRED_W = $clog2(OUT_CREDITS + 1);

    typedef logic [HIST_ADDR_W-1:0] hist_addr_t;
    typedef logic [7:0] hist_byte_t;
    typedef logic [LEN_W-1:0] match_len_t;
    typedef logic [NUM_LANES-1:0] lane_strb_t;

    typedef logic [REQ_CRED_W-1:0] req_cred_t;
    typedef logic [RESP_CRED_W-1:0] resp_cred_t;
    typedef logic [OUT_CRED_W-1:0] out_cred_t;

    typedef struct packed {
        hist_addr_t head_addr;
        hist_addr_t hist_addr;
    } lane_req_t;

    typedef struct packed {
        lane_req_t  req1;
        lane_req_t  req0;
        lane_strb_t strb;
    } req_group_t;

endpackage

// ==== src/match_cluster.sv ====
module match_cluster (
    input  logic                     clk,
    input  logic                     i_arst_n,

    input  logic                     i_req_valid,
    input  lz_match_pkg::hist_addr_t i_req_head_addr0,
    input  lz_match_pkg::hist_addr_t i_req_hist_addr0,
    input  lz_match_pkg::hist_addr_t i_req_head_addr1,
    input  lz_match_pkg::hist_addr_t i_req_hist_addr1,
    input  lz_match_pkg::lane_strb_t i_req_strb,
    output logic                     o_req_credit,

    input  logic                     i_wr_en,
    input  lz_match_pkg::hist_addr_t i_wr_addr,
    input  lz_match_pkg::hist_byte_t i_wr_data,

    output logic                     o_resp_valid,
    output lz_match_pkg::lane_strb_t o_resp_strb,
    output lz_match_pkg::match_len_t o_resp_len0,
    output lz_match_pkg::match_len_t o_resp_len1,
    output logic                     o_resp_best,
    input  logic                     i_resp_credit
);

    lz_match_pkg::req_group_t req_group;
    logic                     issue_valid;
    lz_match_pkg::lane_strb_t issue_strb;

    match_lane_if lane0_if ();
    match_lane_if lane1_if ();

    assign req_group.req0.head_addr = i_req_head_addr0;
    assign req_group.req0.hist_addr = i_req_hist_addr0;
    assign req_group.req1.head_addr = i_req_head_addr1;
    assign req_group.req1.hist_addr = i_req_hist_addr1;
    assign req_group.strb = i_req_strb;

    match_req_scheduler sched_i (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_req_valid   (i_req_valid),
        .i_req_group   (req_group),
        .o_req_credit  (o_req_credit),
        .lane0         (lane0_if),
        .lane1         (lane1_if),
        .o_issue_valid (issue_valid),
        .o_issue_strb  (issue_strb)
    );

    // both engines see every history write
    match_engine engine0_i (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .lane      (lane0_if)
    );

    match_engine engine1_i (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .lane      (lane1_if)
    );

    match_resp_sync sync_i (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_issue_valid (issue_valid),
        .i_issue_strb  (issue_strb),
        .lane0         (lane0_if),
        .lane1         (lane1_if),
        .i_resp_credit (i_resp_credit),
        .o_resp_valid  (o_resp_valid),
        .o_resp_strb   (o_resp_strb),
        .o_resp_len0   (o_resp_len0),
        .o_resp_len1   (o_resp_len1),
        .o_resp_best   (o_resp_best)
    );

endmodule

// ==== src/match_engine.sv ====
module match_engine (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_wr_en,
    input  lz_match_pkg::hist_addr_t i_wr_addr,
    input  lz_match_pkg::hist_byte_t i_wr_data,
    match_lane_if.engine             lane
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMP,
        ST_RESP
    } state_t;

    state_t state;

    lz_match_pkg::hist_byte_t   hist_mem [lz_match_pkg::HIST_SIZE];

    lz_match_pkg::lane_req_t    fifo_head;
    logic                       fifo_empty;
    logic                       take;

    lz_match_pkg::hist_addr_t   rd_head_addr;
    lz_match_pkg::hist_addr_t   rd_hist_addr;
    lz_match_pkg::match_len_t   run_len;
    logic                       byte_eq;
    logic                       at_cap;
    lz_match_pkg::resp_cred_t   resp_cred;

    credit_fifo #(
        .T     (lz_match_pkg::lane_req_t),
        .DEPTH (lz_match_pkg::LANE_REQ_DEPTH)
    ) req_fifo_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_push   (lane.req_valid),
        .i_data   (lane.req),
        .i_pop    (take),
        .o_data   (fifo_head),
        .o_empty  (fifo_empty)
    );

    // private history copy written in step with the other lane
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            hist_mem[i_wr_addr] <= i_wr_data;
        end
    end

    // only start a job when its response already has a slot downstream
    assign take = (state == ST_IDLE) && !fifo_empty && (resp_cred != '0);
    assign lane.req_credit = take;

    assign byte_eq = (hist_mem[rd_head_addr] == hist_mem[rd_hist_addr]);
    assign at_cap = (run_len == lz_match_pkg::match_len_t'(lz_match_pkg::MAX_MATCH_LEN - 1));

    assign lane.resp_valid = (state == ST_RESP) && (resp_cred != '0);
    assign lane.resp_len = run_len;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        state <= ST_CMP;
                    end
                end
                ST_CMP: begin
                    // stop on the first mismatch or once the cap is reached
                    if (!byte_eq || at_cap) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (lane.resp_valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // compare pointers step together and wrap at the end of the history
    always_ff @(posedge clk) begin
        if (take) begin
            rd_head_addr <= fifo_head.head_addr;
            rd_hist_addr <= fifo_head.hist_addr;
            run_len <= '0;
        end else if ((state == ST_CMP) && byte_eq) begin
            rd_head_addr <= rd_head_addr + 1'b1;
            rd_hist_addr <= rd_hist_addr + 1'b1;
            run_len <= run_len + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            resp_cred <= lz_match_pkg::resp_cred_t'(lz_match_pkg::LANE_RESP_DEPTH);
        end else begin
            resp_cred <= resp_cred + lz_match_pkg::resp_cred_t'(lane.resp_credit)
                         - lz_match_pkg::resp_cred_t'(lane.resp_valid);
        end
    end

endmodule

// ==== src/match_lane_if.sv ====
interface match_lane_if;

    logic                     req_valid;
    lz_match_pkg::lane_req_t  req;
    logic                     req_credit;

    logic                     resp_valid;
    lz_match_pkg::match_len_t resp_len;
    logic                     resp_credit;

    modport sched (
        output req_valid,
        output req,
        input  req_credit
    );

    modport engine (
        input  req_valid,
        input  req,
        output req_credit,
        output resp_valid,
        output resp_len,
        input  resp_credit
    );

    modport sync (
        input  resp_valid,
        input  resp_len,
        output resp_credit
    );

endinterface

// ==== src/match_req_scheduler.sv ====
module match_req_scheduler (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_req_valid,
    input  lz_match_pkg::req_group_t i_req_group,
    output logic                     o_req_credit,
    match_lane_if.sched              lane0,
    match_lane_if.sched              lane1,
    output logic                     o_issue_valid,
    output lz_match_pkg::lane_strb_t o_issue_strb
);

    lz_match_pkg::req_group_t head_group;
    logic                     grp_empty;
    logic                     issue;
    logic                     lane0_ok;
    logic                     lane1_ok;
    lz_match_pkg::req_cred_t  lane0_cred;
    lz_match_pkg::req_cred_t  lane1_cred;

    credit_fifo #(
        .T     (lz_match_pkg::req_group_t),
        .DEPTH (lz_match_pkg::REQ_GROUP_DEPTH)
    ) grp_fifo_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_push   (i_req_valid),
        .i_data   (i_req_group),
        .i_pop    (issue),
        .o_data   (head_group),
        .o_empty  (grp_empty)
    );

    // a lane without its strobe bit needs no credit
    assign lane0_ok = !head_group.strb[0] || (lane0_cred != '0);
    assign lane1_ok = !head_group.strb[1] || (lane1_cred != '0);
    assign issue = !grp_empty && lane0_ok && lane1_ok;

    assign lane0.req_valid = issue && head_group.strb[0];
    assign lane0.req = head_group.req0;
    assign lane1.req_valid = issue && head_group.strb[1];
    assign lane1.req = head_group.req1;

    assign o_issue_valid = issue;
    assign o_issue_strb = head_group.strb;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_req_credit <= 1'b0;
            lane0_cred <= lz_match_pkg::req_cred_t'(lz_match_pkg::LANE_REQ_DEPTH);
            lane1_cred <= lz_match_pkg::req_cred_t'(lz_match_pkg::LANE_REQ_DEPTH);
        end else begin
            o_req_credit <= issue;
            lane0_cred <= lane0_cred + lz_match_pkg::req_cred_t'(lane0.req_credit)
                          - lz_match_pkg::req_cred_t'(lane0.req_valid);
            lane1_cred <= lane1_cred + lz_match_pkg::req_cred_t'(lane1.req_credit)
                          - lz_match_pkg::req_cred_t'(lane1.req_valid);
        end
    end

endmodule

// ==== src/match_resp_sync.sv ====
module match_resp_sync (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_issue_valid,
    input  lz_match_pkg::lane_strb_t i_issue_strb,
    match_lane_if.sync               lane0,
    match_lane_if.sync               lane1,
    input  logic                     i_resp_credit,
    output logic                     o_resp_valid,
    output lz_match_pkg::lane_strb_t o_resp_strb,
    output lz_match_pkg::match_len_t o_resp_len0,
    output lz_match_pkg::match_len_t o_resp_len1,
    output logic                     o_resp_best
);

    lz_match_pkg::lane_strb_t grp_strb;
    logic                     strb_empty;
    lz_match_pkg::match_len_t len0;
    lz_match_pkg::match_len_t len1;
    logic                     len0_empty;
    logic                     len1_empty;
    logic                     lane0_rdy;
    logic                     lane1_rdy;
    logic                     emit;
    lz_match_pkg::out_cred_t  out_cred;

    // one strobe per group in issue order
    credit_fifo #(
        .T     (lz_match_pkg::lane_strb_t),
        .DEPTH (lz_match_pkg::ISSUE_DEPTH)
    ) strb_fifo_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_push   (i_issue_valid),
        .i_data   (i_issue_strb),
        .i_pop    (emit),
        .o_data   (grp_strb),
        .o_empty  (strb_empty)
    );

    credit_fifo #(
        .T     (lz_match_pkg::match_len_t),
        .DEPTH (lz_match_pkg::LANE_RESP_DEPTH)
    ) len0_fifo_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_push   (lane0.resp_valid),
        .i_data   (lane0.resp_len),
        .i_pop    (emit && grp_strb[0]),
        .o_data   (len0),
        .o_empty  (len0_empty)
    );

    credit_fifo #(
        .T     (lz_match_pkg::match_len_t),
        .DEPTH (lz_match_pkg::LANE_RESP_DEPTH)
    ) len1_fifo_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_push   (lane1.resp_valid),
        .i_data   (lane1.resp_len),
        .i_pop    (emit && grp_strb[1]),
        .o_data   (len1),
        .o_empty  (len1_empty)
    );

    // lanes answer in order, so the heads belong to the oldest group
    assign lane0_rdy = !grp_strb[0] || !len0_empty;
    assign lane1_rdy = !grp_strb[1] || !len1_empty;
    assign emit = !strb_empty && lane0_rdy && lane1_rdy && (out_cred != '0);

    assign o_resp_valid = emit;
    assign o_resp_strb = grp_strb;
    assign o_resp_len0 = grp_strb[0] ? len0 : '0;
    assign o_resp_len1 = grp_strb[1] ? len1 : '0;
    // tie goes to lane 0
    assign o_resp_best = grp_strb[1] && (!grp_strb[0] || (len1 > len0));

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            lane0.resp_credit <= 1'b0;
            lane1.resp_credit <= 1'b0;
            out_cred <= lz_match_pkg::out_cred_t'(lz_match_pkg::OUT_CREDITS);
        end else begin
            lane0.resp_credit <= emit && grp_strb[0];
            lane1.resp_credit <= emit && grp_strb[1];
            out_cred <= out_cred + lz_match_pkg::out_cred_t'(i_resp_credit)
                        - lz_match_pkg::out_cred_t'(emit);
        end
    end

endmodule

// ==== tb.f ====
src/lz_match_pkg.sv
src/match_lane_if.sv
src/credit_fifo.sv
src/match_req_scheduler.sv
src/match_engine.sv
src/match_resp_sync.sv
src/match_cluster.sv
testbench/tb_clock_gen.sv
testbench/match_cluster_sva.sv
testbench/match_cluster_tb.sv

// ==== testbench/match_cluster_sva.sv ====
module match_cluster_sva (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_resp_valid,
    input  lz_match_pkg::lane_strb_t i_resp_strb,
    input  lz_match_pkg::match_len_t i_resp_len0,
    input  lz_match_pkg::match_len_t i_resp_len1,
    input  lz_match_pkg::out_cred_t  i_out_cred
);

    timeunit 1ns;
    timeprecision 100ps;

    // an underflow would wrap the counter above its reset value
    credit_in_range_a: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_out_cred <= lz_match_pkg::out_cred_t'(lz_match_pkg::OUT_CREDITS)
    ) else $error("output credit counter out of range: %0d", i_out_cred);

    strb_nonzero_a: assert property (
        @(posedge clk) disable iff (!i_arst_n) i_resp_valid |-> (i_resp_strb != '0)
    ) else $error("group response with an empty lane strobe");

    len_capped_a: assert property (
        @(posedge clk) disable iff (!i_arst_n) i_resp_valid |->
            (i_resp_len0 <= lz_match_pkg::match_len_t'(lz_match_pkg::MAX_MATCH_LEN)) &&
            (i_resp_len1 <= lz_match_pkg::match_len_t'(lz_match_pkg::MAX_MATCH_LEN))
    ) else $error("match length above the cap: %0d / %0d", i_resp_len0, i_resp_len1);

endmodule

bind match_resp_sync match_cluster_sva sva_i (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_resp_valid (o_resp_valid),
    .i_resp_strb  (o_resp_strb),
    .i_resp_len0  (o_resp_len0),
    .i_resp_len1  (o_resp_len1),
    .i_out_cred   (out_cred)
);

// ==== testbench/match_cluster_tb.sv ====
module match_cluster_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TOTAL_GROUPS = 61;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_GROUPS * (lz_match_pkg::MAX_MATCH_LEN + 4);
    localparam int SEED = 32'hfe4c;

    typedef struct packed {
        lz_match_pkg::lane_strb_t strb;
        lz_match_pkg::match_len_t len0;
        lz_match_pkg::match_len_t len1;
        logic                     best;
    } exp_resp_t;

    logic                     clk;
    logic                     arst_n;
    logic                     i_req_valid;
    lz_match_pkg::hist_addr_t i_req_head_addr0;
    lz_match_pkg::hist_addr_t i_req_hist_addr0;
    lz_match_pkg::hist_addr_t i_req_head_addr1;
    lz_match_pkg::hist_addr_t i_req_hist_addr1;
    lz_match_pkg::lane_strb_t i_req_strb;
    logic                     o_req_credit;
    logic                     i_wr_en;
    lz_match_pkg::hist_addr_t i_wr_addr;
    lz_match_pkg::hist_byte_t i_wr_data;
    logic                     o_resp_valid;
    lz_match_pkg::lane_strb_t o_resp_strb;
    lz_match_pkg::match_len_t o_resp_len0;
    lz_match_pkg::match_len_t o_resp_len1;
    logic                     o_resp_best;
    logic                     i_resp_credit = 1'b0;

    lz_match_pkg::hist_byte_t hist_model [lz_match_pkg::HIST_SIZE];
    exp_resp_t                exp_q [$];

    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     groups_sent = 0;
    int     req_credits_back = 0;
    int     resp_seen = 0;
    int     credits_owed = 0;
    int     credits_given = 0;
    logic   hold_credits = 1'b0;
    logic   rand_credit = 1'b0;
    integer seed;
    integer credit_seed;

    tb_clock_gen clk_gen_i (
        .o_clk    (clk),
        .o_arst_n (arst_n)
    );

    match_cluster dut_i (
        .i_arst_n (arst_n),
        .*
    );

    function automatic int ref_match_len(int head, int hist);
        int len;
        len = 0;
        while (len < lz_match_pkg::MAX_MATCH_LEN &&
               hist_model[lz_match_pkg::hist_addr_t'(head + len)] ==
               hist_model[lz_match_pkg::hist_addr_t'(hist + len)]) begin
            len++;
        end
        return len;
    endfunction

    task automatic check_value(string name, int actual, int expected);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // every byte differs, so a match only exists where bytes were copied
    task automatic fill_distinct();
        for (int i = 0; i < lz_match_pkg::HIST_SIZE; i++) begin
            hist_model[lz_match_pkg::hist_addr_t'(i)] = lz_match_pkg::hist_byte_t'(i);
        end
    endtask

    task automatic copy_bytes(int dst, int src, int n);
        for (int i = 0; i < n; i++) begin
            hist_model[lz_match_pkg::hist_addr_t'(dst + i)] =
                hist_model[lz_match_pkg::hist_addr_t'(src + i)];
        end
    endtask

    task automatic load_history();
        for (int i = 0; i < lz_match_pkg::HIST_SIZE; i++) begin
            i_wr_en = 1'b1;
            i_wr_addr = lz_match_pkg::hist_addr_t'(i);
            i_wr_data = hist_model[lz_match_pkg::hist_addr_t'(i)];
            @(negedge clk);
        end
        i_wr_en = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic send_group(lz_match_pkg::lane_strb_t strb, int h0, int s0, int h1, int s1);
        exp_resp_t exp;
        int        len0;
        int        len1;
        while (lz_match_pkg::REQ_GROUP_DEPTH + req_credits_back - groups_sent <= 0) begin
            @(negedge clk);
        end
        len0 = strb[0] ? ref_match_len(h0, s0) : 0;
        len1 = strb[1] ? ref_match_len(h1, s1) : 0;
        exp.strb = strb;
        exp.len0 = lz_match_pkg::match_len_t'(len0);
        exp.len1 = lz_match_pkg::match_len_t'(len1);
        if (strb == 2'b10) begin
            exp.best = 1'b1;
        end else if (strb == 2'b01) begin
            exp.best = 1'b0;
        end else begin
            exp.best = (len1 > len0);
        end
        exp_q.push_back(exp);
        i_req_valid = 1'b1;
        i_req_strb = strb;
        i_req_head_addr0 = lz_match_pkg::hist_addr_t'(h0);
        i_req_hist_addr0 = lz_match_pkg::hist_addr_t'(s0);
        i_req_head_addr1 = lz_match_pkg::hist_addr_t'(h1);
        i_req_hist_addr1 = lz_match_pkg::hist_addr_t'(s1);
        groups_sent++;
        @(negedge clk);
        i_req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic single_lane_groups();
        $display("test: single lane");
        drain();
        fill_distinct();
        copy_bytes(100, 0, 3);
        copy_bytes(200, 0, 7);
        load_history();
        // the idle lane points at equal addresses, which would give 16 if used
        send_group(2'b01, 0, 50, 0, 0);
        send_group(2'b01, 0, 100, 0, 0);
        send_group(2'b01, 0, 200, 0, 0);
        send_group(2'b10, 0, 0, 0, 50);
        send_group(2'b10, 0, 0, 0, 100);
        send_group(2'b10, 0, 0, 0, 200);
        drain();
    endtask

    task automatic both_lanes_best();
        $display("test: both lanes and best lane");
        send_group(2'b11, 0, 100, 0, 200);
        send_group(2'b11, 0, 200, 0, 100);
        send_group(2'b11, 0, 100, 0, 100);
        send_group(2'b11, 0, 50, 0, 50);
        drain();
    endtask

    task automatic cap_and_wrap();
        $display("test: cap and wrap");
        fill_distinct();
        copy_bytes(60, 10, 20);
        copy_bytes(150, 250, 10);
        load_history();
        send_group(2'b11, 10, 60, 250, 150);
        send_group(2'b11, 252, 252, 60, 10);
        send_group(2'b01, 255, 255, 0, 0);
        drain();
    endtask

    task automatic backpressure_order();
        int resp_start;
        int credit_snap;
        $display("test: back-pressure and order");
        // the sink settles the credit of the last beat before holding back
        while (credits_given != credits_owed) begin
            @(negedge clk);
        end
        hold_credits = 1'b1;
        resp_start = resp_seen;
        for (int k = 0; k < 8; k++) begin
            send_group(2'b11, 10 + k, 60 + k, 250 + k, 150 + k);
        end
        repeat (200) @(negedge clk);
        credit_snap = req_credits_back;
        repeat (50) @(negedge clk);
        assert (req_credits_back == credit_snap) else begin
            errors++;
            $display("o_req_credit kept pulsing while the sink held back its credits");
        end
        assert (resp_seen - resp_start <= lz_match_pkg::OUT_CREDITS) else begin
            errors++;
            $display("%0d responses left without sink credits", resp_seen - resp_start);
        end
        hold_credits = 1'b0;
        drain();
    endtask

    task automatic random_groups();
        lz_match_pkg::lane_strb_t strb;
        int                       h0;
        int                       s0;
        int                       h1;
        int                       s1;
        $display("test: random groups");
        drain();
        // four symbols make long runs common
        for (int i = 0; i < lz_match_pkg::HIST_SIZE; i++) begin
            hist_model[lz_match_pkg::hist_addr_t'(i)] =
                lz_match_pkg::hist_byte_t'($random(seed) & 3);
        end
        load_history();
        rand_credit = 1'b1;
        for (int g = 0; g < 40; g++) begin
            strb = lz_match_pkg::lane_strb_t'($random(seed) & 3);
            if (strb == 2'b00) begin
                strb = 2'b11;
            end
            h0 = $random(seed) & 255;
            s0 = $random(seed) & 255;
            h1 = $random(seed) & 255;
            s1 = $random(seed) & 255;
            send_group(strb, h0, s0, h1, s1);
            repeat ($random(seed) & 3) @(negedge clk);
        end
        drain();
        rand_credit = 1'b0;
    endtask

    // response monitor, credit bookkeeping and watchdog
    always @(posedge clk) begin
        exp_resp_t exp;
        cycles++;
        if (arst_n) begin
            if (o_req_credit) begin
                req_credits_back++;
            end
            if (o_resp_valid) begin
                resp_seen++;
                credits_owed++;
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("response at %0d ns with no request outstanding", $time);
                end
                if (exp_q.size() != 0) begin
                    exp = exp_q.pop_front();
                    check_value("o_resp_strb", int'(o_resp_strb), int'(exp.strb));
                    check_value("o_resp_len0", int'(o_resp_len0), int'(exp.len0));
                    check_value("o_resp_len1", int'(o_resp_len1), int'(exp.len1));
                    check_value("o_resp_best", int'(o_resp_best), int'(exp.best));
                end
            end
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            errors++;
            $display("timeout after %0d cycles, %0d responses missing", cycles, exp_q.size());
            finish_run();
        end
    end

    // the sink frees a slot one cycle after each beat unless held back
    always @(negedge clk) begin
        if (credits_owed > credits_given && !hold_credits &&
            (!rand_credit || ($random(credit_seed) & 1) != 0)) begin
            i_resp_credit = 1'b1;
            credits_given++;
        end else begin
            i_resp_credit = 1'b0;
        end
    end

    initial begin
        i_req_valid = 1'b0;
        i_req_head_addr0 = '0;
        i_req_hist_addr0 = '0;
        i_req_head_addr1 = '0;
        i_req_hist_addr1 = '0;
        i_req_strb = '0;
        i_wr_en = 1'b0;
        i_wr_addr = '0;
        i_wr_data = '0;
        seed = SEED;
        // separate stream so credit timing does not shift the stimulus
        credit_seed = SEED ^ 32'h0000_a5a5;
        wait (arst_n === 1'b1);
        @(negedge clk);
        single_lane_groups();
        both_lanes_best();
        cap_and_wrap();
        backpressure_order();
        random_groups();
        repeat (10) @(negedge clk);
        assert (req_credits_back == groups_sent) else begin
            errors++;
            $display("%0d input credits came back for %0d groups", req_credits_back, groups_sent);
        end
        finish_run();
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic o_clk,
    output logic o_arst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD_NS = 4;
    localparam int RESET_CYCLES = 5;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end

    // release on a falling edge away from the sampling edge of the flops
    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_arst_n = 1'b1;
    end

endmodule
